/* Makefile */
VERILATOR    ?= verilator
TOP          := merge_sorter_tb
FILE_LIST    := src.f
BUILD_DIR    := obj_dir
LINT_FLAGS   := --lint-only --timing --assert
SIM_FLAGS    := --binary --timing --assert -Wno-fatal -j 0
PASS_MESSAGE := NO ERRORS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MESSAGE)"

clean:
	rm -rf $(BUILD_DIR)

/* hdl/merge_sequencer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sorts one block at a time and loads it into bank 0
// The block must end with in_last by SORT_MAX_LENGTH words
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module merge_sequencer (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  sort_data_pkg::data_t   in_data,
    input  sort_data_pkg::tag_t    in_tag,
    input  logic                   in_last,
    output logic                   out_valid,
    input  logic                   out_ready,
    output sort_data_pkg::data_t   out_data,
    output sort_data_pkg::tag_t    out_tag,
    output logic                   out_last,
    output logic                   busy,
    output logic                   fetch_start,
    output sort_data_pkg::addr_t   base_a,
    output sort_data_pkg::addr_t   base_b,
    output sort_data_pkg::length_t length_a,
    output sort_data_pkg::length_t length_b,
    output logic                   merge_start,
    input  logic                   merged_valid,
    output logic                   merged_ready,
    input  sort_data_pkg::data_t   merged_data,
    input  sort_data_pkg::tag_t    merged_tag,
    input  logic                   merged_last,
    input  logic                   merge_done,
    output logic                   read_bank,
    output logic                   write_en,
    output sort_data_pkg::addr_t   write_addr,
    output sort_data_pkg::data_t   write_data,
    output sort_data_pkg::tag_t    write_tag
);
    import sort_data_pkg::*;
    import sort_ctrl_pkg::*;

    sorter_state_t state;
    length_t       block_length;
    length_t       width;
    length_t       pair_base;
    length_t       b_start;
    length_t       next_base;
    length_t       left_a;
    length_t       left_b;
    addr_t         write_ptr;
    logic          in_fire;
    logic          out_fire;

    assign in_ready = (state == load);
    assign busy     = (state != load);
    assign in_fire  = in_valid && in_ready;

    // Run b of each pair is clipped to the end of the block
    assign b_start   = pair_base + width;
    assign next_base = b_start + width;
    assign left_a    = block_length - pair_base;
    assign left_b    = (b_start < block_length) ? block_length - b_start : '0;

    // The unload uses the same geometry, as width then covers the whole block
    assign fetch_start = (state == pass_start) || (state == unload_start);
    assign merge_start = fetch_start;
    assign base_a      = addr_t'(pair_base);
    assign base_b      = addr_t'(b_start);
    assign length_a    = (left_a < width) ? left_a : width;
    assign length_b    = (left_b < width) ? left_b : width;

    assign merged_ready = (state == pass_merge) || (state == unload && out_ready);
    assign out_valid    = (state == unload) && merged_valid;
    assign out_data     = merged_data;
    assign out_tag      = merged_tag;
    assign out_last     = (state == unload) && merged_last;
    assign out_fire     = out_valid && out_ready;

    assign write_en   = in_fire || (state == pass_merge && merged_valid);
    assign write_addr = write_ptr;
    assign write_data = (state == load) ? in_data : merged_data;
    assign write_tag  = (state == load) ? in_tag : merged_tag;

    always_ff @(posedge clock) begin
        if (reset) begin
            state        <= load;
            block_length <= '0;
            width        <= '0;
            pair_base    <= '0;
            write_ptr    <= '0;
            read_bank    <= 1'b1;
        end else begin
            if (write_en) begin
                write_ptr <= write_ptr + 1'b1;
            end
            case (state)
                load: begin
                    if (in_fire) begin
                        block_length <= block_length + 1'b1;
                        if (in_last) begin
                            width     <= length_t'(1);
                            pair_base <= '0;
                            write_ptr <= '0;
                            read_bank <= 1'b0;
                            // A single word is already sorted
                            state <= (block_length == '0) ? unload_start : pass_start;
                        end
                    end
                end
                pass_start: state <= pass_merge;
                pass_merge: begin
                    if (merge_done) begin
                        if (next_base < block_length) begin
                            pair_base <= next_base;
                            state     <= pass_start;
                        end else begin
                            pair_base <= '0;
                            write_ptr <= '0;
                            width     <= width << 1;
                            read_bank <= ~read_bank;
                            if ((width << 1) >= block_length) begin
                                state <= unload_start;
                            end else begin
                                state <= pass_start;
                            end
                        end
                    end
                end
                unload_start: state <= unload;
                unload: begin
                    if (out_fire && out_last) begin
                        block_length <= '0;
                        read_bank    <= 1'b1;
                        state        <= load;
                    end
                end
                default: state <= load;
            endcase
        end
    end

endmodule

/* hdl/merge_sorter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stable ascending block sorter whose in_ready is low while busy
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module merge_sorter (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  sort_data_pkg::data_t in_data,
    input  sort_data_pkg::tag_t  in_tag,
    input  logic                 in_last,
    output logic                 out_valid,
    input  logic                 out_ready,
    output sort_data_pkg::data_t out_data,
    output sort_data_pkg::tag_t  out_tag,
    output logic                 out_last,
    output logic                 busy
);
    import sort_data_pkg::*;

    logic    fetch_start;
    logic    merge_start;
    logic    merge_done;
    addr_t   base_a;
    addr_t   base_b;
    length_t length_a;
    length_t length_b;
    logic    read_bank;
    addr_t   read_addr_a;
    addr_t   read_addr_b;
    data_t   read_data_a;
    data_t   read_data_b;
    tag_t    read_tag_a;
    tag_t    read_tag_b;
    logic    write_en;
    addr_t   write_addr;
    data_t   write_data;
    tag_t    write_tag;

    // Fetch to core streams
    logic    a_valid;
    logic    b_valid;
    logic    a_ready;
    logic    b_ready;
    data_t   a_data;
    data_t   b_data;
    tag_t    a_tag;
    tag_t    b_tag;

    // Core to sequencer stream
    logic    merged_valid;
    logic    merged_ready;
    data_t   merged_data;
    tag_t    merged_tag;
    logic    merged_last;

    merge_sequencer i_merge_sequencer (.*);

    run_fetch i_run_fetch (.*);

    merging_core i_merging_core (.*);

    ping_pong_store i_ping_pong_store (.*);

endmodule

/* hdl/merging_core.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Both input runs must already be ascending
// merge_start is only taken while the core is idle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module merging_core (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   merge_start,
    input  sort_data_pkg::length_t length_a,
    input  sort_data_pkg::length_t length_b,
    input  logic                   a_valid,
    input  logic                   b_valid,
    output logic                   a_ready,
    output logic                   b_ready,
    input  sort_data_pkg::data_t   a_data,
    input  sort_data_pkg::data_t   b_data,
    input  sort_data_pkg::tag_t    a_tag,
    input  sort_data_pkg::tag_t    b_tag,
    output logic                   merged_valid,
    input  logic                   merged_ready,
    output sort_data_pkg::data_t   merged_data,
    output sort_data_pkg::tag_t    merged_tag,
    output logic                   merged_last,
    output logic                   merge_done
);
    import sort_data_pkg::*;
    import sort_ctrl_pkg::*;

    merge_state_t state;
    length_t      left_a;
    length_t      left_b;
    logic         take_b;
    logic         a_fire;
    logic         b_fire;
    logic         merged_fire;

    // B wins only on a strictly smaller key, so ties keep run a first
    assign take_b      = (b_data < a_data);
    assign a_fire      = a_valid && a_ready;
    assign b_fire      = b_valid && b_ready;
    assign merged_fire = merged_valid && merged_ready;
    assign merged_last = merged_valid && ((left_a + left_b) == 1);

    always_comb begin
        merged_valid = 1'b0;
        a_ready      = 1'b0;
        b_ready      = 1'b0;
        merged_data  = a_data;
        merged_tag   = a_tag;
        case (state)
            merge_ab: begin
                merged_valid = a_valid && b_valid;
                a_ready      = merged_ready && merged_valid && !take_b;
                b_ready      = merged_ready && merged_valid && take_b;
                if (take_b) begin
                    merged_data = b_data;
                    merged_tag  = b_tag;
                end
            end
            drain_a: begin
                merged_valid = a_valid;
                a_ready      = merged_ready;
            end
            drain_b: begin
                merged_valid = b_valid;
                b_ready      = merged_ready;
                merged_data  = b_data;
                merged_tag   = b_tag;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= idle;
            left_a     <= '0;
            left_b     <= '0;
            merge_done <= 1'b0;
        end else begin
            merge_done <= merged_fire && merged_last;
            if (a_fire) begin
                left_a <= left_a - 1'b1;
            end
            if (b_fire) begin
                left_b <= left_b - 1'b1;
            end
            case (state)
                idle: begin
                    if (merge_start) begin
                        left_a <= length_a;
                        left_b <= length_b;
                        if (length_b == '0) begin
                            state <= drain_a;
                        end else if (length_a == '0) begin
                            state <= drain_b;
                        end else begin
                            state <= merge_ab;
                        end
                    end
                end
                merge_ab: begin
                    // Once one run is used up the rest of the other is copied
                    if (a_fire && left_a == 1) begin
                        state <= drain_b;
                    end
                    if (b_fire && left_b == 1) begin
                        state <= drain_a;
                    end
                end
                default: begin
                    if (merged_fire && merged_last) begin
                        state <= idle;
                    end
                end
            endcase
        end
    end

endmodule

/* hdl/ping_pong_store.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reads are combinational and writes land on the clock edge
// The write port always targets the bank not being read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "sorter_params.svh"

module ping_pong_store (
    input  logic                 clock,
    input  logic                 read_bank,
    input  sort_data_pkg::addr_t read_addr_a,
    input  sort_data_pkg::addr_t read_addr_b,
    output sort_data_pkg::data_t read_data_a,
    output sort_data_pkg::data_t read_data_b,
    output sort_data_pkg::tag_t  read_tag_a,
    output sort_data_pkg::tag_t  read_tag_b,
    input  logic                 write_en,
    input  sort_data_pkg::addr_t write_addr,
    input  sort_data_pkg::data_t write_data,
    input  sort_data_pkg::tag_t  write_tag
);
    import sort_data_pkg::*;

    data_t data_mem [2][`SORT_MAX_LENGTH];
    tag_t  tag_mem  [2][`SORT_MAX_LENGTH];

    assign read_data_a = data_mem[read_bank][read_addr_a];
    assign read_data_b = data_mem[read_bank][read_addr_b];
    assign read_tag_a  = tag_mem[read_bank][read_addr_a];
    assign read_tag_b  = tag_mem[read_bank][read_addr_b];

    always_ff @(posedge clock) begin
        if (write_en) begin
            data_mem[~read_bank][write_addr] <= write_data;
            tag_mem[~read_bank][write_addr]  <= write_tag;
        end
    end

endmodule

/* hdl/run_fetch.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Streams two runs out of the store at one word per transfer
// A new fetch_start overrides any words still left
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module run_fetch (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   fetch_start,
    input  sort_data_pkg::addr_t   base_a,
    input  sort_data_pkg::addr_t   base_b,
    input  sort_data_pkg::length_t length_a,
    input  sort_data_pkg::length_t length_b,
    output sort_data_pkg::addr_t   read_addr_a,
    output sort_data_pkg::addr_t   read_addr_b,
    input  sort_data_pkg::data_t   read_data_a,
    input  sort_data_pkg::data_t   read_data_b,
    input  sort_data_pkg::tag_t    read_tag_a,
    input  sort_data_pkg::tag_t    read_tag_b,
    output logic                   a_valid,
    output logic                   b_valid,
    input  logic                   a_ready,
    input  logic                   b_ready,
    output sort_data_pkg::data_t   a_data,
    output sort_data_pkg::data_t   b_data,
    output sort_data_pkg::tag_t    a_tag,
    output sort_data_pkg::tag_t    b_tag
);
    import sort_data_pkg::*;

    addr_t   addr_a;
    addr_t   addr_b;
    length_t count_a;
    length_t count_b;

    // The head of each run is whatever the store shows at its address
    assign read_addr_a = addr_a;
    assign read_addr_b = addr_b;
    assign a_data      = read_data_a;
    assign b_data      = read_data_b;
    assign a_tag       = read_tag_a;
    assign b_tag       = read_tag_b;

    assign a_valid = (count_a != '0);
    assign b_valid = (count_b != '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            count_a <= '0;
            count_b <= '0;
        end else if (fetch_start) begin
            count_a <= length_a;
            count_b <= length_b;
        end else begin
            if (a_valid && a_ready) begin
                count_a <= count_a - 1'b1;
            end
            if (b_valid && b_ready) begin
                count_b <= count_b - 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (fetch_start) begin
            addr_a <= base_a;
            addr_b <= base_b;
        end else begin
            if (a_valid && a_ready) begin
                addr_a <= addr_a + 1'b1;
            end
            if (b_valid && b_ready) begin
                addr_b <= addr_b + 1'b1;
            end
        end
    end

endmodule

/* hdl/sort_ctrl_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// State encodings of the merging core and sequencer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package sort_ctrl_pkg;

    // Merging core
    typedef enum logic [1:0] {
        idle     = 2'd0,
        merge_ab = 2'd1,
        drain_a  = 2'd2,
        drain_b  = 2'd3
    } merge_state_t;

    // Block sequencer
    typedef enum logic [2:0] {
        load         = 3'd0,
        pass_start   = 3'd1,
        pass_merge   = 3'd2,
        unload_start = 3'd3,
        unload       = 3'd4
    } sorter_state_t;

endpackage

/* hdl/sort_data_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Word, tag, address and length types of the sorter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "sorter_params.svh"

package sort_data_pkg;

    typedef logic [`SORT_DATA_WIDTH-1:0] data_t;

    // The tag rides along with its key and never takes part in the compare
    typedef logic [`SORT_INDEX_WIDTH-1:0] tag_t;

    typedef logic [`SORT_INDEX_WIDTH-1:0] addr_t;

    // One bit wider than an address so that a full block fits
    typedef logic [`SORT_INDEX_WIDTH:0] length_t;

endpackage

/* hdl/sorter_params.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Compile-time sizes of the block sorter
// SORT_INDEX_WIDTH must equal $clog2(SORT_MAX_LENGTH)
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef SORTER_PARAMS_SVH
`define SORTER_PARAMS_SVH

// Key width in bits
`define SORT_DATA_WIDTH 16
// Largest block in words
`define SORT_MAX_LENGTH 16
`define SORT_INDEX_WIDTH 4

`endif

/* src.f */
+incdir+hdl
hdl/sort_data_pkg.sv
hdl/sort_ctrl_pkg.sv
hdl/ping_pong_store.sv
hdl/run_fetch.sv
hdl/merging_core.sv
hdl/merge_sequencer.sv
hdl/merge_sorter.sv
verif/merge_sorter_tb.sv

/* verif/merge_sorter_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sends one block at a time and checks the sorted output stream
// Tags carry the arrival index, so a block can hold 16 words at most
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "sorter_params.svh"

module merge_sorter_tb;
    import sort_data_pkg::*;

    localparam int CLOCK_PERIOD    = 20;
    localparam int DRIVE_DELAY     = 2;
    localparam int NUM_BLOCKS      = 22;
    localparam int WATCHDOG_CYCLES = NUM_BLOCKS * (`SORT_MAX_LENGTH * 8 + 50);

    logic  clock = 1'b0;
    logic  reset;
    logic  in_valid;
    logic  in_ready;
    data_t in_data;
    tag_t  in_tag;
    logic  in_last;
    logic  out_valid;
    logic  out_ready;
    data_t out_data;
    tag_t  out_tag;
    logic  out_last;
    logic  busy;

    integer seed = 32'h4889;
    string  test_name = "reset";

    // Scoreboard state is updated on the clock edge
    data_t                       block_data [`SORT_MAX_LENGTH];
    int                          block_len;
    int                          load_count;
    int                          out_count;
    int                          blocks_done;
    int                          words_in;
    int                          words_out;
    data_t                       prev_data;
    tag_t                        prev_tag;
    logic [`SORT_MAX_LENGTH-1:0] seen_tags;
    logic                        stall_pending;
    data_t                       stall_data;
    tag_t                        stall_tag;

    wire in_fire  = in_valid && in_ready;
    wire out_fire = out_valid && out_ready;

    merge_sorter i_merge_sorter (.*);

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic report_mismatch(input string check, input int expected, input int actual);
        stop_with_failure($sformatf("ERROR %s/%s: expected 0x%0h, actual 0x%0h",
                                    test_name, check, expected, actual));
    endtask

    // Drives one block with keys from a small range so that ties are common
    task automatic send_block(input string name, input int length);
        int i;
        while (!in_ready) begin
            @(posedge clock);
            #DRIVE_DELAY;
        end
        test_name = name;
        for (i = 0; i < length; i++) begin
            in_valid = 1'b1;
            in_data  = data_t'($random(seed) & 7);
            in_tag   = tag_t'(i);
            in_last  = (i == length - 1);
            @(posedge clock);
            #DRIVE_DELAY;
        end
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    always begin
        @(posedge clock);
        #DRIVE_DELAY;
        out_ready = (($random(seed) & 3) != 0);
    end

    always @(posedge clock) begin
        if (reset) begin
            load_count    <= 0;
            out_count     <= 0;
            blocks_done   <= 0;
            words_in      <= 0;
            words_out     <= 0;
            seen_tags     <= '0;
            stall_pending <= 1'b0;
        end else begin
            stall_pending <= out_valid && !out_ready;
            stall_data    <= out_data;
            stall_tag     <= out_tag;
            if (in_fire) begin
                block_data[in_tag] <= in_data;
                words_in <= words_in + 1;
                if (in_last) begin
                    block_len  <= load_count + 1;
                    load_count <= 0;
                end else begin
                    load_count <= load_count + 1;
                end
            end
            if (out_fire) begin
                prev_data <= out_data;
                prev_tag  <= out_tag;
                words_out <= words_out + 1;
                if (out_last) begin
                    out_count   <= 0;
                    seen_tags   <= '0;
                    blocks_done <= blocks_done + 1;
                end else begin
                    out_count          <= out_count + 1;
                    seen_tags[out_tag] <= 1'b1;
                end
            end
        end
    end

    order_check: assert property (@(posedge clock) disable iff (reset)
        out_fire && out_count != 0 |-> out_data >= prev_data)
        else report_mismatch("order", int'($sampled(prev_data)), int'($sampled(out_data)));

    content_check: assert property (@(posedge clock) disable iff (reset)
        out_fire |-> out_data == block_data[out_tag])
        else report_mismatch("content", int'(block_data[$sampled(out_tag)]),
                             int'($sampled(out_data)));

    tag_range_check: assert property (@(posedge clock) disable iff (reset)
        out_fire |-> int'(out_tag) < block_len)
        else report_mismatch("tag_range", $sampled(block_len) - 1, int'($sampled(out_tag)));

    // Together with the framing check this makes every tag appear exactly once
    unique_tag_check: assert property (@(posedge clock) disable iff (reset)
        out_fire |-> !seen_tags[out_tag])
        else report_mismatch("unique_tag", 0, int'($sampled(out_tag)));

    stability_check: assert property (@(posedge clock) disable iff (reset)
        out_fire && out_count != 0 && out_data == prev_data |-> out_tag > prev_tag)
        else report_mismatch("stability", int'($sampled(prev_tag)) + 1, int'($sampled(out_tag)));

    framing_check: assert property (@(posedge clock) disable iff (reset)
        out_fire |-> out_last == (out_count + 1 == block_len))
        else report_mismatch("framing", int'($sampled(out_count) + 1 == $sampled(block_len)),
                             int'($sampled(out_last)));

    hold_valid_check: assert property (@(posedge clock) disable iff (reset)
        stall_pending |-> out_valid)
        else report_mismatch("hold_valid", 1, int'($sampled(out_valid)));

    hold_data_check: assert property (@(posedge clock) disable iff (reset)
        stall_pending |-> {out_data, out_tag} == {stall_data, stall_tag})
        else report_mismatch("hold_data", int'({$sampled(stall_data), $sampled(stall_tag)}),
                             int'({$sampled(out_data), $sampled(out_tag)}));

    in_ready_check: assert property (@(posedge clock) disable iff (reset)
        busy |-> !in_ready)
        else report_mismatch("in_ready_busy", 0, int'($sampled(in_ready)));

    // The sorter turns busy once the last word of a block has been taken
    busy_check: assert property (@(posedge clock) disable iff (reset)
        in_fire && in_last |=> busy)
        else report_mismatch("busy", 1, int'($sampled(busy)));

    initial begin
        #((WATCHDOG_CYCLES + 2) * CLOCK_PERIOD);
        stop_with_failure($sformatf("Timeout: only %0d of %0d blocks came out in time",
                                    blocks_done, NUM_BLOCKS));
    end

    initial begin
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_data   = '0;
        in_tag    = '0;
        in_last   = 1'b0;
        out_ready = 1'b0;
        repeat (2) @(posedge clock);
        #DRIVE_DELAY;
        reset = 1'b0;
        assert (in_ready && !busy && !out_valid)
            else report_mismatch("reset_state", 3'b100, int'({in_ready, busy, out_valid}));
        send_block("single_word", 1);
        send_block("full_block", `SORT_MAX_LENGTH);
        repeat (NUM_BLOCKS - 2) begin
            send_block("random_block", 1 + $unsigned($random(seed)) % `SORT_MAX_LENGTH);
        end
        wait (blocks_done == NUM_BLOCKS);
        @(posedge clock);
        #DRIVE_DELAY;
        if (words_out == words_in) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            report_mismatch("word_count", words_in, words_out);
        end
    end

endmodule
